// ==== clint/hart_timer.sv ====
// --------------------
// Per-hart msip and mtimecmp with timer interrupt
// --------------------

`default_nettype none

module hart_timer (
  input  logic             clk_i,
  input  logic             ndmreset_n,
  input  logic             msip_we_i,
  input  logic             mtimecmp_we_i,
  input  clint_pkg::word_t wdata_i,
  input  clint_pkg::word_t mtime_i,
  output logic             msip_o,
  output clint_pkg::word_t mtimecmp_o,
  output logic             timer_irq_o
);

  import clint_pkg::*;

  logic  msip_q;
  word_t mtimecmp_q;

  // Software interrupt pending bit
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q <= 1'b0;
    end else if (msip_we_i) begin
      msip_q <= wdata_i[0];
    end
  end

  // All ones keeps the timer interrupt quiet until software arms it
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtimecmp_q <= '1;
    end else if (mtimecmp_we_i) begin
      mtimecmp_q <= wdata_i;
    end
  end

  assign msip_o      = msip_q;
  assign mtimecmp_o  = mtimecmp_q;
  assign timer_irq_o = (mtime_i >= mtimecmp_q);

  // Decoder never targets both registers of a hart at once
  a_single_we: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    !(msip_we_i && mtimecmp_we_i));

endmodule

`default_nettype wire

// ==== clint/mtime_counter.sv ====
// --------------------
// RTC pulse divider and shared mtime
// --------------------

`default_nettype none

module mtime_counter (
  input  logic             clk_i,
  input  logic             ndmreset_n,
  input  logic             rtc_i,
  output clint_pkg::word_t mtime_o
);

  import clint_pkg::*;

  localparam int unsigned DivW = (RtcDivide > 1) ? $clog2(RtcDivide) : 1;

  logic [DivW-1:0] rtc_cnt_q;
  word_t           mtime_q;
  logic            tick;

  // Last pulse of each group advances mtime
  assign tick = rtc_i && (rtc_cnt_q == DivW'(RtcDivide - 1));

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_cnt_q <= '0;
    end else if (tick) begin
      rtc_cnt_q <= '0;
    end else if (rtc_i) begin
      rtc_cnt_q <= rtc_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      mtime_q <= '0;
    end else if (tick) begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  assign mtime_o = mtime_q;

endmodule

`default_nettype wire

// ==== common/clint_pkg.sv ====
// --------------------
// CLINT widths, register map and register-kind type
// --------------------

`default_nettype none

package clint_pkg;

  // --------------------
  // Widths
  // --------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 64;

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] word_t;

  // --------------------
  // Address rule
  // --------------------
  localparam addr_t ClintBase   = 32'h0200_0000;
  localparam addr_t ClintLength = 32'h0001_0000;

  // Offsets inside the CLINT window
  // msip of hart h at MsipOffset + 4*h
  localparam addr_t MsipOffset     = 32'h0000_0000;
  // mtimecmp of hart h at MtimecmpOffset + 8*h
  localparam addr_t MtimecmpOffset = 32'h0000_4000;
  localparam addr_t MtimeOffset    = 32'h0000_BFF8;

  // --------------------
  // Timer and hart limits
  // --------------------

  // rtc pulses per mtime tick
  localparam int unsigned RtcDivide = 2;

  // Largest hart count the map supports
  localparam int unsigned MaxHarts = 8;

  // Register selected by a read
  typedef enum logic [1:0] {
    REG_NONE     = 2'd0,
    REG_MSIP     = 2'd1,
    REG_MTIMECMP = 2'd2,
    REG_MTIME    = 2'd3
  } reg_kind_e;

endpackage

`default_nettype wire

// ==== compile.f ====
common/clint_pkg.sv
src/clint_addr_decode.sv
clint/mtime_counter.sv
clint/hart_timer.sv
src/clint_read_mux.sv
src/debug_req_gate.sv
src/clint_subsystem.sv
test/tb_clint_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the CLINT testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_clint_subsystem -o Vtb_clint_subsystem > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vtb_clint_subsystem > sim.log 2>&1 || echo "Simulator exited with an error"

grep -q "TEST PASSED" sim.log && echo "Simulation passed" \
  || { cat sim.log; echo "Simulation failed"; exit 1; }

// ==== src/clint_addr_decode.sv ====
// --------------------
// CLINT request decoder: write strobes and read selection
// --------------------

`default_nettype none

module clint_addr_decode #(
  parameter int unsigned NUM_HARTS = 2,
  localparam int unsigned HartIdxW = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1
) (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  req_i,
  input  logic                  we_i,
  input  clint_pkg::addr_t      addr_i,
  output logic [NUM_HARTS-1:0]  msip_we_o,
  output logic [NUM_HARTS-1:0]  mtimecmp_we_o,
  output logic                  rd_o,
  output clint_pkg::reg_kind_e  rd_kind_o,
  output logic [HartIdxW-1:0]   rd_hart_o
);

  import clint_pkg::*;

  logic  in_rule;
  addr_t offset;
  addr_t msip_idx;
  addr_t cmp_idx;
  logic  msip_hit;
  logic  cmp_hit;
  logic  mtime_hit;
  logic [HartIdxW-1:0] hart_idx;

  assign in_rule = (addr_i >= ClintBase) && (addr_i < ClintBase + ClintLength);
  assign offset  = addr_i - ClintBase;

  assign msip_idx = (offset - MsipOffset) >> 2;
  assign cmp_idx  = (offset - MtimecmpOffset) >> 3;

  // Word-aligned windows, bounded by the map and by the hart count
  assign msip_hit = in_rule && (offset >= MsipOffset) &&
                    (offset < MsipOffset + addr_t'(4 * MaxHarts)) &&
                    (offset[1:0] == 2'b00) && (msip_idx < NUM_HARTS);
  assign cmp_hit  = in_rule && (offset >= MtimecmpOffset) &&
                    (offset < MtimecmpOffset + addr_t'(8 * MaxHarts)) &&
                    (offset[2:0] == 3'b000) && (cmp_idx < NUM_HARTS);
  assign mtime_hit = in_rule && (offset == MtimeOffset);

  assign hart_idx = msip_hit ? msip_idx[HartIdxW-1:0] : cmp_idx[HartIdxW-1:0];

  always_comb begin
    msip_we_o     = '0;
    mtimecmp_we_o = '0;
    rd_kind_o     = REG_NONE;
    if (msip_hit) begin
      rd_kind_o = REG_MSIP;
    end else if (cmp_hit) begin
      rd_kind_o = REG_MTIMECMP;
    end else if (mtime_hit) begin
      rd_kind_o = REG_MTIME;
    end
    // mtime is read-only, so only two strobe kinds
    if (req_i && we_i) begin
      if (msip_hit) begin
        msip_we_o[hart_idx] = 1'b1;
      end
      if (cmp_hit) begin
        mtimecmp_we_o[hart_idx] = 1'b1;
      end
    end
  end

  assign rd_o      = req_i && !we_i;
  assign rd_hart_o = hart_idx;

  // At most one register of one hart takes a write
  a_we_onehot: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    $onehot0({msip_we_o, mtimecmp_we_o}));

endmodule

`default_nettype wire

// ==== src/clint_read_mux.sv ====
// --------------------
// CLINT read data select and return register
// --------------------

`default_nettype none

module clint_read_mux #(
  parameter int unsigned NUM_HARTS = 2,
  localparam int unsigned HartIdxW = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1
) (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic                 rd_i,
  input  clint_pkg::reg_kind_e rd_kind_i,
  input  logic [HartIdxW-1:0]  rd_hart_i,
  input  logic [NUM_HARTS-1:0] msip_i,
  input  clint_pkg::word_t     mtimecmp_i [NUM_HARTS],
  input  clint_pkg::word_t     mtime_i,
  output clint_pkg::word_t     rdata_o,
  output logic                 rvalid_o
);

  import clint_pkg::*;

  word_t rdata_d;
  word_t rdata_q;
  logic  rvalid_q;

  always_comb begin
    case (rd_kind_i)
      REG_MSIP:     rdata_d = {{(DataWidth-1){1'b0}}, msip_i[rd_hart_i]};
      REG_MTIMECMP: rdata_d = mtimecmp_i[rd_hart_i];
      REG_MTIME:    rdata_d = mtime_i;
      default:      rdata_d = '0;
    endcase
  end

  // One cycle read latency
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= rd_i;
      if (rd_i) begin
        rdata_q <= rdata_d;
      end
    end
  end

  assign rdata_o  = rdata_q;
  assign rvalid_o = rvalid_q;

  // Back-to-back valids need back-to-back reads
  a_rvalid_pair: assert property (@(posedge clk_i) disable iff (!ndmreset_n)
    (rvalid_o && $past(rvalid_o)) |-> ($past(rd_i, 1) && $past(rd_i, 2)));

endmodule

`default_nettype wire

// ==== src/clint_subsystem.sv ====
// --------------------
// CLINT subsystem top: decode, hart timers, read return, debug gate
// --------------------

`default_nettype none

module clint_subsystem #(
  parameter int unsigned NUM_HARTS          = 2,
  parameter int unsigned DEBUG_DELAY_CYCLES = 500
) (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic                 rtc_i,
  // Register port
  input  logic                 req_i,
  input  logic                 we_i,
  input  clint_pkg::addr_t     addr_i,
  input  clint_pkg::word_t     wdata_i,
  output clint_pkg::word_t     rdata_o,
  output logic                 rvalid_o,
  // Interrupts
  output logic [NUM_HARTS-1:0] timer_irq_o,
  output logic [NUM_HARTS-1:0] ipi_o,
  // Debug requests
  input  logic [NUM_HARTS-1:0] debug_req_i,
  output logic [NUM_HARTS-1:0] debug_req_o
);

  import clint_pkg::*;

  localparam int unsigned HartIdxW = (NUM_HARTS > 1) ? $clog2(NUM_HARTS) : 1;

  logic [NUM_HARTS-1:0] msip_we;
  logic [NUM_HARTS-1:0] mtimecmp_we;
  logic                 rd;
  reg_kind_e            rd_kind;
  logic [HartIdxW-1:0]  rd_hart;
  word_t                mtime;
  word_t                mtimecmp [NUM_HARTS];

  // --------------------
  // Decode
  // --------------------
  clint_addr_decode #(
    .NUM_HARTS     ( NUM_HARTS   )
  ) i_addr_decode (
    .clk_i         ( clk_i       ),
    .ndmreset_n    ( ndmreset_n  ),
    .req_i         ( req_i       ),
    .we_i          ( we_i        ),
    .addr_i        ( addr_i      ),
    .msip_we_o     ( msip_we     ),
    .mtimecmp_we_o ( mtimecmp_we ),
    .rd_o          ( rd          ),
    .rd_kind_o     ( rd_kind     ),
    .rd_hart_o     ( rd_hart     )
  );

  mtime_counter i_mtime_counter (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .rtc_i      ( rtc_i      ),
    .mtime_o    ( mtime      )
  );

  // --------------------
  // Per-hart registers
  // --------------------
  for (genvar h = 0; h < NUM_HARTS; h++) begin : g_hart
    hart_timer i_hart_timer (
      .clk_i         ( clk_i          ),
      .ndmreset_n    ( ndmreset_n     ),
      .msip_we_i     ( msip_we[h]     ),
      .mtimecmp_we_i ( mtimecmp_we[h] ),
      .wdata_i       ( wdata_i        ),
      .mtime_i       ( mtime          ),
      .msip_o        ( ipi_o[h]       ),
      .mtimecmp_o    ( mtimecmp[h]    ),
      .timer_irq_o   ( timer_irq_o[h] )
    );
  end

  clint_read_mux #(
    .NUM_HARTS  ( NUM_HARTS  )
  ) i_read_mux (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .rd_i       ( rd         ),
    .rd_kind_i  ( rd_kind    ),
    .rd_hart_i  ( rd_hart    ),
    .msip_i     ( ipi_o      ),
    .mtimecmp_i ( mtimecmp   ),
    .mtime_i    ( mtime      ),
    .rdata_o    ( rdata_o    ),
    .rvalid_o   ( rvalid_o   )
  );

  // --------------------
  // Debug hold-off
  // --------------------
  debug_req_gate #(
    .NUM_HARTS          ( NUM_HARTS          ),
    .DEBUG_DELAY_CYCLES ( DEBUG_DELAY_CYCLES )
  ) i_debug_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

`default_nettype wire

// ==== src/debug_req_gate.sv ====
// --------------------
// Debug request hold-off after reset
// --------------------

`default_nettype none

module debug_req_gate #(
  parameter int unsigned NUM_HARTS          = 2,
  parameter int unsigned DEBUG_DELAY_CYCLES = 500
) (
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic [NUM_HARTS-1:0] debug_req_i,
  output logic [NUM_HARTS-1:0] debug_req_o
);

  localparam int unsigned CntW = $clog2(DEBUG_DELAY_CYCLES + 1);

  logic [CntW-1:0] delay_cnt_q;
  logic            open;

  // Counts down once per cycle and sticks at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      delay_cnt_q <= CntW'(DEBUG_DELAY_CYCLES);
    end else if (!open) begin
      delay_cnt_q <= delay_cnt_q - 1'b1;
    end
  end

  assign open        = (delay_cnt_q == '0);
  assign debug_req_o = open ? debug_req_i : '0;

endmodule

`default_nettype wire

// ==== test/clint_patterns.txt ====
# op arg_a arg_b, all hex. W addr data | R addr expected | P pulses 0
# I timer_irq ipi | D debug_req_i expected_debug_req_o
R 02004000 FFFFFFFFFFFFFFFF
R 02004008 FFFFFFFFFFFFFFFF
R 02000000 0
R 02000004 0
R 0200BFF8 0
I 0 0
D 3 3
D 1 1
D 2 2
D 0 0
W 02004008 0123456789ABCDEF
R 02004008 0123456789ABCDEF
W 02004000 00000000DEADBEEF
R 02004000 00000000DEADBEEF
W 02000004 1
I 0 2
R 02000004 1
R 02000000 0
W 02000000 FFFFFFFF
I 0 3
W 02000004 0
I 0 1
W 02000000 2
I 0 0
W 02004000 3
P 4 0
I 0 0
R 0200BFF8 2
P 2 0
I 1 0
R 0200BFF8 3
R 01FFFFF8 0
W 01FFFFF8 5
R 02010000 0
W 02000008 1
I 1 0
R 02000008 0
R 02000002 0
W 02004010 0
R 02004010 0
R 02004000 3
R 02004008 0123456789ABCDEF
W 0200BFF8 0
R 0200BFF8 3
I 1 0

// ==== test/tb_clint_subsystem.sv ====
// --------------------
// Testbench for the CLINT subsystem: clock, reset, pattern reader,
// compare tasks and watchdog
// --------------------

`default_nettype none

module tb_clint_subsystem;

  timeunit 1ns;
  timeprecision 1ps;

  import clint_pkg::*;

  localparam int unsigned NumHarts     = 2;
  localparam int unsigned DebugDelay   = 20;
  localparam int unsigned ClkPeriod    = 4;
  localparam int unsigned ResetCycles  = 10;
  localparam int unsigned CyclesPerOp  = 40;
  localparam int unsigned HoldoffCheck = DebugDelay + 5;

  logic                clk_i;
  logic                ndmreset_n;
  logic                rtc_i;
  logic                req_i;
  logic                we_i;
  addr_t               addr_i;
  word_t               wdata_i;
  word_t               rdata_o;
  logic                rvalid_o;
  logic [NumHarts-1:0] timer_irq_o;
  logic [NumHarts-1:0] ipi_o;
  logic [NumHarts-1:0] debug_req_i;
  logic [NumHarts-1:0] debug_req_o;

  string       op_q [$];
  word_t       arg_a_q [$];
  word_t       arg_b_q [$];
  int unsigned error_count;
  longint      timeout_ns;

  clint_subsystem #(
    .NUM_HARTS          ( NumHarts   ),
    .DEBUG_DELAY_CYCLES ( DebugDelay )
  ) clint_subsystem_i (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .req_i       ( req_i       ),
    .we_i        ( we_i        ),
    .addr_i      ( addr_i      ),
    .wdata_i     ( wdata_i     ),
    .rdata_o     ( rdata_o     ),
    .rvalid_o    ( rvalid_o    ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  // --------------------
  // Failure and compare tasks
  // --------------------
  task automatic stop_with_failure(input string msg);
    error_count++;
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  task automatic check_bits(input string name, input logic [NumHarts-1:0] exp,
                            input logic [NumHarts-1:0] act);
    if (act !== exp) begin
      stop_with_failure($sformatf("[FAIL] %s expected 0x%h actual 0x%h", name, exp, act));
    end
  endtask

  // --------------------
  // Bus and pin drivers
  // --------------------
  task automatic bus_write(input addr_t addr, input word_t data);
    req_i   = 1'b1;
    we_i    = 1'b1;
    addr_i  = addr;
    wdata_i = data;
    @(negedge clk_i);
    req_i   = 1'b0;
    we_i    = 1'b0;
  endtask

  // Read data comes back one cycle after the request, for one cycle only
  task automatic bus_read_check(input addr_t addr, input word_t exp);
    req_i  = 1'b1;
    we_i   = 1'b0;
    addr_i = addr;
    @(negedge clk_i);
    if (rvalid_o !== 1'b1) begin
      stop_with_failure($sformatf("No read valid one cycle after read of 0x%h", addr));
    end
    check_word("rdata_o", exp, rdata_o);
    req_i = 1'b0;
    @(negedge clk_i);
    if (rvalid_o !== 1'b0) begin
      stop_with_failure($sformatf("Read valid lasted two cycles after read of 0x%h", addr));
    end
  endtask

  task automatic rtc_pulses(input int unsigned count);
    repeat (count) begin
      rtc_i = 1'b1;
      @(negedge clk_i);
    end
    rtc_i = 1'b0;
  endtask

  task automatic debug_drive_check(input logic [NumHarts-1:0] drive,
                                   input logic [NumHarts-1:0] exp);
    debug_req_i = drive;
    @(negedge clk_i);
    check_bits("debug_req_o", exp, debug_req_o);
  endtask

  // Requests stay blocked for DebugDelay edges after reset release
  task automatic check_debug_holdoff();
    logic [NumHarts-1:0] exp;
    for (int k = 0; k < HoldoffCheck; k++) begin
      exp = (k < DebugDelay) ? '0 : '1;
      check_bits("debug_req_o", exp, debug_req_o);
      @(negedge clk_i);
    end
  endtask

  // --------------------
  // Pattern file
  // --------------------
  task automatic load_patterns();
    int    fd;
    int    code;
    int    fields;
    string line;
    string op;
    word_t arg_a;
    word_t arg_b;
    fd = $fopen("test/clint_patterns.txt", "r");
    if (fd == 0) begin
      stop_with_failure("Could not open pattern file test/clint_patterns.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (code != 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
        fields = $sscanf(line, "%s %h %h", op, arg_a, arg_b);
        if (fields != 3) begin
          stop_with_failure($sformatf("Malformed pattern line: %s", line));
        end
        op_q.push_back(op);
        arg_a_q.push_back(arg_a);
        arg_b_q.push_back(arg_b);
      end
    end
    $fclose(fd);
  endtask

  task automatic run_op(input string op, input word_t arg_a, input word_t arg_b);
    case (op)
      "W": bus_write(addr_t'(arg_a), arg_b);
      "R": bus_read_check(addr_t'(arg_a), arg_b);
      "P": rtc_pulses(int'(arg_a));
      "I": begin
        check_bits("timer_irq_o", arg_a[NumHarts-1:0], timer_irq_o);
        check_bits("ipi_o", arg_b[NumHarts-1:0], ipi_o);
      end
      "D": debug_drive_check(arg_a[NumHarts-1:0], arg_b[NumHarts-1:0]);
      default: stop_with_failure($sformatf("Unknown pattern operation %s", op));
    endcase
  endtask

  // --------------------
  // Watchdog
  // --------------------
  initial begin
    wait (timeout_ns > 0);
    #(timeout_ns);
    $display("Watchdog expired before the pattern run finished");
    $display("TEST FAILED");
    $fatal(1, "Timeout");
  end

  initial begin : main
    error_count = 0;
    timeout_ns  = 0;
    ndmreset_n  = 1'b0;
    rtc_i       = 1'b0;
    req_i       = 1'b0;
    we_i        = 1'b0;
    addr_i      = '0;
    wdata_i     = '0;
    debug_req_i = '1;

    load_patterns();
    timeout_ns = longint'(ResetCycles + HoldoffCheck + CyclesPerOp * op_q.size()) *
                 ClkPeriod;

    repeat (ResetCycles) @(negedge clk_i);
    ndmreset_n = 1'b1;

    check_debug_holdoff();
    for (int i = 0; i < op_q.size(); i++) begin
      run_op(op_q[i], arg_a_q[i], arg_b_q[i]);
    end

    @(negedge clk_i);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
